// File: filelist.f
hw/des_pkg.sv
hw/des_step_if.sv
hw/des_ctrl.sv
hw/des_key_sched.sv
hw/des_sbox_bank.sv
hw/des_round.sv
hw/des_core.sv
verif/des_tb.sv

// File: hw/des_core.sv
//--------------------------------------
// DES core top level
// Iterative DES encrypt/decrypt with valid/ready ports
//--------------------------------------
`timescale 1ns/1ps

module des_core #(
  parameter int ROUNDS_PER_CYCLE = 1
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  output logic        in_ready,
  input  logic        in_decrypt,
  input  logic [63:0] in_key,
  input  logic [63:0] in_data,
  output logic        out_valid,
  input  logic        out_ready,
  output logic [63:0] out_data
);

  logic [ROUNDS_PER_CYCLE-1:0][47:0] subkeys;

  des_step_if step_bus ();

  des_ctrl #(
    .ROUNDS_PER_CYCLE (ROUNDS_PER_CYCLE)
  ) u_des_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_decrypt (in_decrypt),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .step       (step_bus.ctrl)
  );

  des_key_sched #(
    .ROUNDS_PER_CYCLE (ROUNDS_PER_CYCLE)
  ) u_des_key_sched (
    .clk     (clk),
    .rst_n   (rst_n),
    .key     (in_key),
    .step    (step_bus.key),
    .subkeys (subkeys)
  );

  des_round #(
    .ROUNDS_PER_CYCLE (ROUNDS_PER_CYCLE)
  ) u_des_round (
    .clk      (clk),
    .rst_n    (rst_n),
    .data     (in_data),
    .step     (step_bus.round),
    .subkeys  (subkeys),
    .data_out (out_data)
  );

endmodule

// File: hw/des_ctrl.sv
//--------------------------------------
// DES controller
// Handshake FSM and round counter
//--------------------------------------
`timescale 1ns/1ps

module des_ctrl
  import des_pkg::*;
#(
  parameter int ROUNDS_PER_CYCLE = 1
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  logic     in_decrypt,
  output logic     out_valid,
  input  logic     out_ready,
  des_step_if.ctrl step
);

  // ROUNDS_PER_CYCLE must divide 16; at 16 the step wraps to zero
  localparam logic [ROUND_IDX_W-1:0] IDX_STEP = ROUND_IDX_W'(ROUNDS_PER_CYCLE);
  localparam logic [ROUND_IDX_W-1:0] IDX_LAST = ROUND_IDX_W'(16 - ROUNDS_PER_CYCLE);

  des_state_e             state_q;
  logic [ROUND_IDX_W-1:0] idx_q;
  des_mode_e              mode_q;
  logic                   accept;

  assign accept = (state_q == ST_IDLE) && in_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      idx_q   <= '0;
      mode_q  <= DES_ENCRYPT;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= ST_RUN;
            idx_q   <= '0;
            mode_q  <= in_decrypt ? DES_DECRYPT : DES_ENCRYPT;
          end
        end
        ST_RUN: begin
          idx_q <= idx_q + IDX_STEP;
          // last batch of rounds executes on this edge
          if (idx_q == IDX_LAST) begin
            state_q <= ST_DONE;
          end
        end
        ST_DONE: begin
          // Result held until the sink takes it
          if (out_ready) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  assign in_ready  = (state_q == ST_IDLE);
  assign out_valid = (state_q == ST_DONE);

  assign step.load      = accept;
  assign step.advance   = (state_q == ST_RUN);
  assign step.round_idx = idx_q;
  assign step.mode      = mode_q;

endmodule

// File: hw/des_key_sched.sv
//--------------------------------------
// DES key schedule
// C/D rotation and PC-2 subkeys, encrypt or decrypt order
//--------------------------------------
`timescale 1ns/1ps

module des_key_sched
  import des_pkg::*;
#(
  parameter int ROUNDS_PER_CYCLE = 1
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [63:0]                       key,
  des_step_if.key                           step,
  output logic [ROUNDS_PER_CYCLE-1:0][47:0] subkeys
);

  logic [27:0] c_q;
  logic [27:0] d_q;
  logic [27:0] c_w;
  logic [27:0] d_w;
  logic [55:0] pc1_key;
  int          rnd;

  function automatic logic [27:0] rotl(input logic [27:0] x, input int amt);
    return (amt == 2) ? {x[25:0], x[27:26]} : {x[26:0], x[27]};
  endfunction

  function automatic logic [27:0] rotr(input logic [27:0] x, input int amt);
    return (amt == 2) ? {x[1:0], x[27:2]} : {x[0], x[27:1]};
  endfunction

  function automatic logic [47:0] pc2(input logic [55:0] cd);
    logic [47:0] k;
    for (int i = 0; i < 48; i++) begin
      k[47-i] = cd[56-PC2_TABLE[i]];
    end
    return k;
  endfunction

  always_comb begin
    for (int i = 0; i < 56; i++) begin
      pc1_key[55-i] = key[64-PC1_TABLE[i]];
    end
  end

  // Walk the halves through every round of this cycle
  always_comb begin
    c_w = c_q;
    d_w = d_q;
    rnd = 0;
    for (int n = 0; n < ROUNDS_PER_CYCLE; n++) begin
      rnd = int'(step.round_idx) + n;
      if (step.mode == DES_ENCRYPT) begin
        c_w = rotl(c_w, SHIFT_TABLE[rnd]);
        d_w = rotl(d_w, SHIFT_TABLE[rnd]);
      end else if (rnd != 0) begin
        // K16 is PC-2 of the loaded halves, later keys undo the mirrored shift
        c_w = rotr(c_w, SHIFT_TABLE[16-rnd]);
        d_w = rotr(d_w, SHIFT_TABLE[16-rnd]);
      end
      subkeys[n] = pc2({c_w, d_w});
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      c_q <= '0;
      d_q <= '0;
    end else if (step.load) begin
      c_q <= pc1_key[55:28];
      d_q <= pc1_key[27:0];
    end else if (step.advance) begin
      c_q <= c_w;
      d_q <= d_w;
    end
  end

endmodule

// File: hw/des_pkg.sv
//--------------------------------------
// DES shared definitions
// Mode/state enums, S-boxes, permutation and shift tables
//--------------------------------------
package des_pkg;

  typedef enum logic {
    DES_ENCRYPT = 1'b0,
    DES_DECRYPT = 1'b1
  } des_mode_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_DONE = 2'd2
  } des_state_e;

  parameter int ROUND_IDX_W = 4;

  // Indexed [box][row][column], row is {b1, b6} and column is b2..b5
  parameter logic [3:0] SBOX_TABLE [8][4][16] = '{
    // S1
    '{'{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7},
      '{ 0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8},
      '{ 4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0},
      '{15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13}},
    // S2
    '{'{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10},
      '{ 3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5},
      '{ 0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15},
      '{13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9}},
    // S3
    '{'{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8},
      '{13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1},
      '{13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7},
      '{ 1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12}},
    // S4
    '{'{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15},
      '{13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9},
      '{10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4},
      '{ 3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14}},
    // S5
    '{'{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9},
      '{14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6},
      '{ 4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14},
      '{11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3}},
    // S6
    '{'{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11},
      '{10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8},
      '{ 9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6},
      '{ 4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13}},
    // S7
    '{'{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1},
      '{13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6},
      '{ 1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2},
      '{ 6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12}},
    // S8
    '{'{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7},
      '{ 1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2},
      '{ 7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8},
      '{ 2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}}
  };

  // Index tables hold 1-based DES bit numbers, DES bit 1 is the vector MSB
  parameter int IP_TABLE [64] = '{
    58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
    62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
    57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
    61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7
  };

  parameter int FP_TABLE [64] = '{
    40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
    38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
    36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
    34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25
  };

  parameter int E_TABLE [48] = '{
    32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,  8,  9, 10, 11,
    12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
    22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
  };

  parameter int P_TABLE [32] = '{
    16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
     2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
  };

  // Parity bits 8, 16, .. 64 never appear here
  parameter int PC1_TABLE [56] = '{
    57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
    10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
    14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
  };

  parameter int PC2_TABLE [48] = '{
    14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10, 23, 19, 12,  4,
    26,  8, 16,  7, 27, 20, 13,  2, 41, 52, 31, 37, 47, 55, 30, 40,
    51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
  };

  // Left rotation per round, sums to 28
  parameter int SHIFT_TABLE [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

endpackage

// File: hw/des_round.sv
//--------------------------------------
// DES block datapath
// IP, L/R registers, unrolled Feistel stages and FP
//--------------------------------------
`timescale 1ns/1ps

module des_round
  import des_pkg::*;
#(
  parameter int ROUNDS_PER_CYCLE = 1
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [63:0]                       data,
  des_step_if.round                         step,
  input  logic [ROUNDS_PER_CYCLE-1:0][47:0] subkeys,
  output logic [63:0]                       data_out
);

  logic [31:0]                       l_q;
  logic [31:0]                       r_q;
  logic [63:0]                       ip_data;
  logic [ROUNDS_PER_CYCLE:0][31:0]   l_s;
  logic [ROUNDS_PER_CYCLE:0][31:0]   r_s;
  logic [ROUNDS_PER_CYCLE-1:0][47:0] x_s;
  logic [ROUNDS_PER_CYCLE-1:0][31:0] s_s;

  function automatic logic [63:0] permute64(input logic [63:0] x, input int tbl [64]);
    logic [63:0] y;
    for (int i = 0; i < 64; i++) begin
      y[63-i] = x[64-tbl[i]];
    end
    return y;
  endfunction

  function automatic logic [47:0] expand(input logic [31:0] r);
    logic [47:0] e;
    for (int i = 0; i < 48; i++) begin
      e[47-i] = r[32-E_TABLE[i]];
    end
    return e;
  endfunction

  function automatic logic [31:0] perm_p(input logic [31:0] s);
    logic [31:0] p;
    for (int i = 0; i < 32; i++) begin
      p[31-i] = s[32-P_TABLE[i]];
    end
    return p;
  endfunction

  assign ip_data = permute64(data, IP_TABLE);

  assign l_s[0] = l_q;
  assign r_s[0] = r_q;

  // One Feistel stage per unrolled round
  for (genvar n = 0; n < ROUNDS_PER_CYCLE; n++) begin : g_stage
    assign x_s[n] = expand(r_s[n]) ^ subkeys[n];

    des_sbox_bank u_sbox_bank (
      .din  (x_s[n]),
      .dout (s_s[n])
    );

    assign l_s[n+1] = r_s[n];
    assign r_s[n+1] = l_s[n] ^ perm_p(s_s[n]);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      l_q <= '0;
      r_q <= '0;
    end else if (step.load) begin
      l_q <= ip_data[63:32];
      r_q <= ip_data[31:0];
    end else if (step.advance) begin
      l_q <= l_s[ROUNDS_PER_CYCLE];
      r_q <= r_s[ROUNDS_PER_CYCLE];
    end
  end

  // Halves swap once more before FP, so R16 goes on top
  assign data_out = permute64({r_q, l_q}, FP_TABLE);

endmodule

// File: hw/des_sbox_bank.sv
//--------------------------------------
// DES S-box bank
// Eight 6-to-4 lookups, 48 bits in and 32 bits out
//--------------------------------------
`timescale 1ns/1ps

module des_sbox_bank
  import des_pkg::*;
(
  input  logic [47:0] din,
  output logic [31:0] dout
);

  // Group g feeds box S(g+1), S1 sits in the top six bits
  for (genvar g = 0; g < 8; g++) begin : g_box
    logic [5:0] grp;
    logic [1:0] row;
    logic [3:0] col;

    assign grp = din[47-6*g -: 6];
    // Outer bits pick the row
    assign row = {grp[5], grp[0]};
    // Middle four bits pick the column
    assign col = grp[4:1];

    assign dout[31-4*g -: 4] = SBOX_TABLE[g][row][col];
  end

endmodule

// File: hw/des_step_if.sv
//--------------------------------------
// DES round-control bus
// Controller to key schedule and datapath
//--------------------------------------
`timescale 1ns/1ps

interface des_step_if
  import des_pkg::*;
();

  // Pulses on the accepting edge
  logic                   load;
  // High for every cycle that executes rounds
  logic                   advance;
  // First round handled in this cycle
  logic [ROUND_IDX_W-1:0] round_idx;
  des_mode_e              mode;

  modport ctrl (
    output load,
    output advance,
    output round_idx,
    output mode
  );

  modport key (
    input load,
    input advance,
    input round_idx,
    input mode
  );

  modport round (
    input load,
    input advance,
    input mode
  );

endinterface

// File: verif/des_tb.sv
//--------------------------------------
// DES core testbench
// Known answers, round trips, back-pressure and reset
//--------------------------------------
`timescale 1ns/1ps

module des_tb;

  localparam int CLK_PERIOD = 20;
  localparam int LATENCY    = 16;
  localparam int MAX_STALL  = 8;
  // Blocks sent over the whole run, sizes the watchdog
  localparam int NUM_BLOCKS = 48;
  localparam int TIMEOUT_NS = NUM_BLOCKS * (LATENCY + MAX_STALL) * CLK_PERIOD * 2;

  // Published DES known-answer vectors
  localparam logic [63:0] KEY1 = 64'h133457799BBCDFF1;
  localparam logic [63:0] PT1  = 64'h0123456789ABCDEF;
  localparam logic [63:0] CT1  = 64'h85E813540F0AB405;
  localparam logic [63:0] KEY2 = 64'h0E329232EA6D0D73;
  localparam logic [63:0] PT2  = 64'h8787878787878787;
  localparam logic [63:0] CT2  = 64'h0000000000000000;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  logic        in_decrypt;
  logic [63:0] in_key;
  logic [63:0] in_data;
  logic        out_valid;
  logic        out_ready;
  logic [63:0] out_data;
  int unsigned seed_init;

  des_core u_des_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_decrypt (in_decrypt),
    .in_key     (in_key),
    .in_data    (in_data),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic expect_equal(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    assert (actual === expected) else begin
      fail_stop($sformatf("** Error @ %0d ns: %s expected 0x%h, actual 0x%h",
                          $time, name, expected, actual));
    end
  endtask

  // Called right after a falling edge, returns one falling edge after acceptance
  task automatic send_block(input logic [63:0] key, input logic [63:0] data,
                            input logic decrypt);
    int waited;
    waited     = 0;
    in_key     = key;
    in_data    = data;
    in_decrypt = decrypt;
    in_valid   = 1'b1;
    while (!in_ready) begin
      @(negedge clk);
      waited++;
      if (waited > 4 * LATENCY) begin
        fail_stop("Input handshake timed out because in_ready stayed low");
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // Counts cycles from acceptance, then holds out_ready low for stall cycles
  task automatic wait_result(input int stall, output logic [63:0] result,
                             output int cycles);
    cycles = 0;
    while (!out_valid) begin
      @(negedge clk);
      cycles++;
      if (cycles > 4 * LATENCY) begin
        fail_stop("Output handshake timed out because out_valid never rose");
      end
    end
    result = out_data;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);
      expect_equal("out_valid", 64'd1, out_valid);
      expect_equal("out_data", result, out_data);
      expect_equal("in_ready", 64'd0, in_ready);
    end
    out_ready = 1'b1;
    @(negedge clk);
    out_ready = 1'b0;
    expect_equal("out_valid", 64'd0, out_valid);
    expect_equal("in_ready", 64'd1, in_ready);
  endtask

  task automatic process_block(input logic [63:0] key, input logic [63:0] data,
                               input logic decrypt, output logic [63:0] result);
    int cycles;
    send_block(key, data, decrypt);
    wait_result(0, result, cycles);
    expect_equal("latency", LATENCY, cycles);
  endtask

  task automatic check_reset_state();
    // Reset is already low from time zero
    @(negedge clk);
    expect_equal("out_valid", 64'd0, out_valid);
    expect_equal("in_ready", 64'd1, in_ready);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    expect_equal("out_valid", 64'd0, out_valid);
    expect_equal("in_ready", 64'd1, in_ready);
  endtask

  task automatic encrypt_known_answers();
    logic [63:0] res;
    process_block(KEY1, PT1, 1'b0, res);
    expect_equal("out_data", CT1, res);
    process_block(KEY2, PT2, 1'b0, res);
    expect_equal("out_data", CT2, res);
  endtask

  task automatic decrypt_known_answers();
    logic [63:0] res;
    process_block(KEY1, CT1, 1'b1, res);
    expect_equal("out_data", PT1, res);
    process_block(KEY2, CT2, 1'b1, res);
    expect_equal("out_data", PT2, res);
  endtask

  task automatic random_round_trip();
    logic [63:0] key;
    logic [63:0] blk;
    logic [63:0] ct;
    logic [63:0] pt;
    for (int i = 0; i < 20; i++) begin
      key = {$urandom, $urandom};
      blk = {$urandom, $urandom};
      process_block(key, blk, 1'b0, ct);
      process_block(key, ct, 1'b1, pt);
      expect_equal("out_data", blk, pt);
    end
  endtask

  task automatic stall_output();
    logic [63:0] res;
    int          cycles;
    int          stall;
    stall = $urandom_range(MAX_STALL, 1);
    send_block(KEY1, PT1, 1'b0);
    // Second block waits at the input through the run and the stall
    in_key     = KEY2;
    in_data    = PT2;
    in_decrypt = 1'b0;
    in_valid   = 1'b1;
    wait_result(stall, res, cycles);
    expect_equal("latency", LATENCY, cycles);
    expect_equal("out_data", CT1, res);
    send_block(KEY2, PT2, 1'b0);
    wait_result(0, res, cycles);
    expect_equal("latency", LATENCY, cycles);
    expect_equal("out_data", CT2, res);
  endtask

  task automatic abort_with_reset();
    logic [63:0] res;
    send_block(KEY1, PT1, 1'b0);
    repeat (5) @(negedge clk);
    expect_equal("in_ready", 64'd0, in_ready);
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    expect_equal("out_valid", 64'd0, out_valid);
    expect_equal("in_ready", 64'd1, in_ready);
    rst_n = 1'b1;
    @(negedge clk);
    expect_equal("out_valid", 64'd0, out_valid);
    expect_equal("in_ready", 64'd1, in_ready);
    // Core must work normally after the aborted block
    process_block(KEY2, PT2, 1'b0, res);
    expect_equal("out_data", CT2, res);
  endtask

  initial begin
    TIMEOUT_WAIT: begin
      #(TIMEOUT_NS);
      fail_stop("Timeout: the tests did not finish in the expected time");
    end
  end

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_decrypt = 1'b0;
    in_key     = '0;
    in_data    = '0;
    out_ready  = 1'b0;
    seed_init  = $urandom(76);

    check_reset_state();
    encrypt_known_answers();
    decrypt_known_answers();
    random_round_trip();
    stall_output();
    abort_with_reset();

    $display("TB PASSED");
    $finish;
  end

endmodule
